/* hdc_cfg.svh */
`ifndef HDC_CFG_SVH
`define HDC_CFG_SVH

// number of cores in the result chain
`define HDC_NUM_CORES 8

// words per item memory
`define HDC_ITEM_DEPTH 128

// symbol index width, covers the item depth
`define HDC_ADDR_W 7

// item and accumulator width
`define HDC_DATA_W 32

// core select width for item writes
`define HDC_CORE_W 3

`endif

/* hdc_pkg.sv */
`include "hdc_cfg.svh"

package hdc_pkg;

    // fold operation for one window
    typedef enum logic {
        op_add,
        op_xor_rot
    } acc_op_e;

    // sequencer states
    typedef enum logic [1:0] {
        st_idle,
        st_accum,
        st_drain
    } seq_state_e;

    // host write into one core's item memory
    typedef struct packed {
        logic                   valid;
        logic [`HDC_CORE_W-1:0] core;
        logic [`HDC_ADDR_W-1:0] addr;
        logic [`HDC_DATA_W-1:0] data;
    } item_wr_t;

    // one symbol of the input stream
    typedef struct packed {
        logic                   valid;
        logic                   last;
        logic [`HDC_ADDR_W-1:0] index;
    } symbol_t;

    // strobes broadcast from the sequencer to every core
    typedef struct packed {
        logic                           exec;
        logic                           first;
        logic [$clog2(`HDC_DATA_W)-1:0] pos;
        logic                           update;
        logic                           shift;
    } core_ctrl_t;

endpackage

/* hdc_core.sv */
`timescale 1ns/10ps
`default_nettype none
`include "hdc_cfg.svh"

module hdc_core #(
    parameter int CORE_ID = 0
) (
    input  logic                   clk,
    input  logic                   rst,
    input  hdc_pkg::item_wr_t      item_wr,
    input  logic [`HDC_ADDR_W-1:0] index,
    input  logic                   sym_valid,
    input  hdc_pkg::core_ctrl_t    ctrl,
    input  hdc_pkg::acc_op_e       op,
    input  logic [`HDC_DATA_W-1:0] chain_in,
    output logic [`HDC_DATA_W-1:0] chain_out
);

    // this core's select code on the item write port
    localparam logic [`HDC_CORE_W-1:0] CORE_SEL = `HDC_CORE_W'(CORE_ID);

    // one item per symbol index, mapped to block ram
    (* ram_style = "block" *)
    logic [`HDC_DATA_W-1:0] item_mem [0:`HDC_ITEM_DEPTH-1];

    // item looked up for the current symbol
    logic [`HDC_DATA_W-1:0] item_q;

    // running value of the open window
    logic [`HDC_DATA_W-1:0] acc;
    logic [`HDC_DATA_W-1:0] fold;

    // snapshot of acc, then a stage of the result shift chain
    logic [`HDC_DATA_W-1:0] result_q;

    logic wr_hit;

    // rotate right, position taken mod data width
    function automatic logic [`HDC_DATA_W-1:0] rot_right(
        input logic [`HDC_DATA_W-1:0]         v,
        input logic [$clog2(`HDC_DATA_W)-1:0] sh
    );
        logic [2*`HDC_DATA_W-1:0] dbl;
        dbl = {v, v} >> sh;
        return dbl[`HDC_DATA_W-1:0];
    endfunction

    // only writes addressed to this core land here
    assign wr_hit = item_wr.valid && (item_wr.core == CORE_SEL);

    always_ff @(posedge clk) begin
        if (wr_hit) begin
            item_mem[item_wr.addr] <= item_wr.data;
        end
    end

    // read port, one cycle ahead of the fold
    always_ff @(posedge clk) begin
        if (sym_valid) begin
            item_q <= item_mem[index];
        end
    end

    // add mode sums, bind mode xors the rotated item
    always_comb begin
        if (op == hdc_pkg::op_xor_rot) begin
            fold = acc ^ rot_right(item_q, ctrl.pos);
        end else begin
            fold = acc + item_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
        end else if (ctrl.exec) begin
            // opening symbol sits at position 0, so no rotation needed
            if (ctrl.first) begin
                acc <= item_q;
            end else begin
                acc <= fold;
            end
        end
    end

    // update loads all cores at once, shift walks results toward core 0
    always_ff @(posedge clk) begin
        if (rst) begin
            result_q <= '0;
        end else if (ctrl.update) begin
            result_q <= acc;
        end else if (ctrl.shift) begin
            result_q <= chain_in;
        end
    end

    assign chain_out = result_q;

endmodule

`default_nettype wire

/* hdc_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none
`include "hdc_cfg.svh"

module hdc_sequencer (
    input  logic                clk,
    input  logic                rst,
    input  hdc_pkg::symbol_t    sym,
    output hdc_pkg::core_ctrl_t ctrl,
    output logic                busy,
    output logic                result_valid
);

    // drain steps: one for update, one for the load, then one per core
    localparam int DRAIN_LAST = `HDC_NUM_CORES + 1;
    localparam int CNT_W      = $clog2(DRAIN_LAST + 1);

    hdc_pkg::seq_state_e state;

    // position of the next accepted symbol in the window
    logic [$clog2(`HDC_DATA_W)-1:0] pos_cnt;

    // cycles spent in drain
    logic [CNT_W-1:0] drain_cnt;

    logic accept;
    logic in_drain;

    assign in_drain = (state == hdc_pkg::st_drain);

    // host must hold off while results are pending
    assign busy = in_drain;

    // symbols seen while busy are dropped here
    assign accept = sym.valid && !busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= hdc_pkg::st_idle;
            drain_cnt <= '0;
        end else begin
            case (state)
                hdc_pkg::st_idle: begin
                    drain_cnt <= '0;
                    if (accept) begin
                        state <= sym.last ? hdc_pkg::st_drain : hdc_pkg::st_accum;
                    end
                end
                hdc_pkg::st_accum: begin
                    drain_cnt <= '0;
                    if (accept && sym.last) begin
                        state <= hdc_pkg::st_drain;
                    end
                end
                hdc_pkg::st_drain: begin
                    // last result leaves as busy drops
                    if (drain_cnt == CNT_W'(DRAIN_LAST)) begin
                        state     <= hdc_pkg::st_idle;
                        drain_cnt <= '0;
                    end else begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                end
                default: begin
                    state     <= hdc_pkg::st_idle;
                    drain_cnt <= '0;
                end
            endcase
        end
    end

    // window position, wraps at the data width
    always_ff @(posedge clk) begin
        if (rst) begin
            pos_cnt <= '0;
        end else if (accept) begin
            if (sym.last) begin
                pos_cnt <= '0;
            end else begin
                pos_cnt <= pos_cnt + 1'b1;
            end
        end
    end

    // exec trails the symbol by one cycle, matching the item read
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl.exec  <= 1'b0;
            ctrl.first <= 1'b0;
            ctrl.pos   <= '0;
        end else begin
            ctrl.exec  <= accept;
            ctrl.first <= accept && (state == hdc_pkg::st_idle);
            if (accept) begin
                ctrl.pos <= pos_cnt;
            end
        end
    end

    // update once the final fold is in, then one shift per output cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl.update  <= 1'b0;
            ctrl.shift   <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            ctrl.update  <= in_drain && (drain_cnt == '0);
            ctrl.shift   <= in_drain && (drain_cnt != '0)
                            && (drain_cnt != CNT_W'(DRAIN_LAST));
            result_valid <= in_drain && (drain_cnt != '0)
                            && (drain_cnt != CNT_W'(DRAIN_LAST));
        end
    end

endmodule

`default_nettype wire

/* hdc_encoder_top.sv */
`timescale 1ns/10ps
`default_nettype none
`include "hdc_cfg.svh"

module hdc_encoder_top (
    input  logic                   clk,
    input  logic                   rst,
    input  hdc_pkg::item_wr_t      item_wr,
    input  hdc_pkg::acc_op_e       op,
    input  hdc_pkg::symbol_t       sym,
    output logic                   busy,
    output logic                   result_valid,
    output logic [`HDC_DATA_W-1:0] result
);

    // shared strobes for the whole core array
    hdc_pkg::core_ctrl_t ctrl;

    // chain[k] is core k's result, chain[NUM_CORES] feeds the top core
    logic [`HDC_DATA_W-1:0] chain [0:`HDC_NUM_CORES];

    hdc_sequencer u_seq (
        .clk          (clk),
        .rst          (rst),
        .sym          (sym),
        .ctrl         (ctrl),
        .busy         (busy),
        .result_valid (result_valid)
    );

    // zeros shift in behind the last core
    assign chain[`HDC_NUM_CORES] = '0;

    // each core sees every symbol, write port filters by core id
    for (genvar k = 0; k < `HDC_NUM_CORES; k++) begin : g_core
        hdc_core #(
            .CORE_ID (k)
        ) u_core (
            .clk       (clk),
            .rst       (rst),
            .item_wr   (item_wr),
            .index     (sym.index),
            .sym_valid (sym.valid),
            .ctrl      (ctrl),
            .op        (op),
            .chain_in  (chain[k+1]),
            .chain_out (chain[k])
        );
    end

    // core 0 sits at the head of the chain
    assign result = chain[0];

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // held over 8 rising edges, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

/* tb_hdc_encoder.sv */
`timescale 1ns/10ps
`default_nettype none
`include "hdc_cfg.svh"

module tb_hdc_encoder;

    logic                   clk;
    logic                   rst;
    hdc_pkg::item_wr_t      item_wr;
    hdc_pkg::acc_op_e       op;
    hdc_pkg::symbol_t       sym;
    logic                   busy;
    logic                   result_valid;
    logic [`HDC_DATA_W-1:0] result;

    // copy of every item memory
    logic [`HDC_DATA_W-1:0] items [0:`HDC_NUM_CORES-1][0:`HDC_ITEM_DEPTH-1];
    // indices of the next window
    logic [`HDC_ADDR_W-1:0] win_idx [0:63];
    integer seed;
    int err_cnt;
    int err_base;
    int n_pass;
    int n_fail;
    int test_no;

    tb_clock_gen u_clk (.clk(clk), .rst(rst));

    hdc_encoder_top dut (.*);

    // results only while the host is held off
    assert property (@(posedge clk) disable iff (rst) result_valid |-> busy)
        else begin
            $display("error %0t busy expected 1 actual %b", $time, $sampled(busy));
            err_cnt++;
        end

    // last result leaves as busy drops
    assert property (@(posedge clk) disable iff (rst) $fell(result_valid) |-> !busy)
        else begin
            $display("error %0t busy expected 0 actual %b", $time, $sampled(busy));
            err_cnt++;
        end

    // rotate right, bit j takes bit j+s
    function automatic logic [`HDC_DATA_W-1:0] rotr_model(
        input logic [`HDC_DATA_W-1:0] v,
        input int                     s
    );
        logic [`HDC_DATA_W-1:0] r;
        for (int j = 0; j < `HDC_DATA_W; j++) begin
            r[j] = v[(j + s) % `HDC_DATA_W];
        end
        return r;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("error %0t %s expected %h actual %h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic write_item(input int core, input int addr, input logic [31:0] data);
        item_wr.valid = 1'b1;
        item_wr.core  = core[`HDC_CORE_W-1:0];
        item_wr.addr  = addr[`HDC_ADDR_W-1:0];
        item_wr.data  = data;
        items[core][addr] = data;
        @(negedge clk);
        item_wr.valid = 1'b0;
    endtask

    task automatic random_window(input int len);
        logic [31:0] r;
        for (int i = 0; i < len; i++) begin
            r = $random(seed);
            win_idx[i] = r[`HDC_ADDR_W-1:0];
        end
    endtask

    // idle cycle, or a stray symbol while busy
    task automatic drive_gap(input bit junk);
        logic [31:0] r;
        r = $random(seed);
        sym.valid = junk && busy;
        sym.last  = r[7];
        sym.index = r[`HDC_ADDR_W-1:0];
    endtask

    task automatic wait_not_busy();
        int n;
        n = 0;
        while (busy && n < 40) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            $display("timeout while waiting for busy to fall");
            err_cnt++;
        end
    endtask

    // sends win_idx[0..len-1] back to back and checks all eight results
    task automatic run_window(input hdc_pkg::acc_op_e op_sel, input int len, input bit junk);
        logic [`HDC_DATA_W-1:0] exp [0:`HDC_NUM_CORES-1];
        logic [`HDC_DATA_W-1:0] it;
        int cyc;
        wait_not_busy();
        for (int k = 0; k < `HDC_NUM_CORES; k++) begin
            exp[k] = '0;
            for (int i = 0; i < len; i++) begin
                it = items[k][win_idx[i]];
                // position wraps every 32 symbols
                if (op_sel == hdc_pkg::op_add) begin
                    exp[k] = exp[k] + it;
                end else begin
                    exp[k] = exp[k] ^ rotr_model(it, i % 32);
                end
            end
        end
        op = op_sel;
        for (int i = 0; i < len; i++) begin
            sym.valid = 1'b1;
            sym.last  = (i == len - 1);
            sym.index = win_idx[i];
            @(negedge clk);
        end
        // one cycle after the last symbol was taken
        check("busy", 1, 32'(busy));
        cyc = 1;
        while (!result_valid && cyc < 12) begin
            drive_gap(junk);
            @(negedge clk);
            cyc++;
        end
        if (!result_valid) begin
            $display("timeout while waiting for result_valid to rise");
            err_cnt++;
        end else begin
            check("result_valid latency", 3, cyc);
            for (int k = 0; k < `HDC_NUM_CORES; k++) begin
                check("result_valid", 1, 32'(result_valid));
                check($sformatf("result core %0d", k), exp[k], result);
                drive_gap(junk);
                @(negedge clk);
            end
            check("result_valid", 0, 32'(result_valid));
            check("busy", 0, 32'(busy));
        end
        sym.valid = 1'b0;
    endtask

    task automatic finish_test(input string name);
        test_no++;
        if (err_cnt == err_base) begin
            n_pass++;
            $display("test %0d %s: ok", test_no, name);
        end else begin
            n_fail++;
            $display("test %0d %s: %0d errors", test_no, name, err_cnt - err_base);
        end
        err_base = err_cnt;
    endtask

    initial begin
        int n;
        logic [31:0] r;
        seed = 18958;
        err_cnt = 0;
        err_base = 0;
        n_pass = 0;
        n_fail = 0;
        test_no = 0;
        item_wr = '0;
        op = hdc_pkg::op_add;
        sym = '0;
        n = 0;
        // rst may still be unknown at time zero
        while (rst !== 1'b0 && n < 40) begin
            @(negedge clk);
            n++;
        end
        if (rst !== 1'b0) begin
            $display("timeout while waiting for reset to end");
            err_cnt++;
        end
        // quiet outputs with no symbols
        repeat (20) begin
            check("busy", 0, 32'(busy));
            check("result_valid", 0, 32'(result_valid));
            check("result", 0, result);
            @(negedge clk);
        end
        finish_test("reset state");
        for (int k = 0; k < `HDC_NUM_CORES; k++) begin
            for (int a = 0; a < `HDC_ITEM_DEPTH; a++) begin
                r = $random(seed);
                write_item(k, a, r);
            end
        end
        random_window(1);
        run_window(hdc_pkg::op_add, 1, 1'b0);
        finish_test("single symbol add");
        random_window(10);
        run_window(hdc_pkg::op_add, 10, 1'b0);
        finish_test("random window add");
        random_window(5);
        run_window(hdc_pkg::op_xor_rot, 5, 1'b0);
        // longer than 32, position wraps
        random_window(40);
        run_window(hdc_pkg::op_xor_rot, 40, 1'b0);
        finish_test("rotate xor windows");
        random_window(6);
        run_window(hdc_pkg::op_xor_rot, 6, 1'b1);
        random_window(7);
        run_window(hdc_pkg::op_add, 7, 1'b1);
        random_window(3);
        run_window(hdc_pkg::op_add, 3, 1'b0);
        finish_test("back-pressure");
        r = $random(seed);
        win_idx[0] = r[`HDC_ADDR_W-1:0];
        run_window(hdc_pkg::op_add, 1, 1'b0);
        // only core 5 changes in the model, the other seven must repeat
        write_item(5, int'(win_idx[0]), ~items[5][win_idx[0]]);
        run_window(hdc_pkg::op_add, 1, 1'b0);
        finish_test("item rewrite");
        $display("tests passed %0d failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
hdc_pkg.sv
hdc_core.sv
hdc_sequencer.sv
hdc_encoder_top.sv
tb_clock_gen.sv
tb_hdc_encoder.sv

/* Bender.yml */
package:
  name: hdc_encoder

sources:
  - include_dirs:
      - "."
    files:
      - hdc_pkg.sv
      - hdc_core.sv
      - hdc_sequencer.sv
      - hdc_encoder_top.sv
  - target: test
    include_dirs:
      - "."
    files:
      - tb_clock_gen.sv
      - tb_hdc_encoder.sv
